// ==== source/cl_macros.svh ====
/* Widths and limits of the Camera Link receive path.
   Included by the packages, the RTL and the testbench. */

`ifndef CL_MACROS_SVH
`define CL_MACROS_SVH

// camera data word as delivered by the deserializer.
`define CL_DATA_W 64

// one pixel and the number of pixels per word in full format.
`define CL_PIXEL_W 16
`define CL_TAPS 4

// frame coordinates and the frame count share this width.
`define CL_COORD_W 16

// the pixel counter restarts on the next enabled word once above this.
`define CL_PIXEL_WRAP 14'h3ff0

// one host read word.
`define CL_STATUS_W 32

`endif

// ==== source/cl_video_pkg.sv ====
/* Types of the pixel stream and its frame timing.
   Imported by the timing tracker, the unpacker and the status port. */

`default_nettype none

`include "cl_macros.svh"

package cl_video_pkg;

  typedef logic [`CL_PIXEL_W-1:0] cl_pixel_t;

  // frame timing derived from fval, lval and dval.
  typedef struct packed {
    logic                   fval_rise;    // first cycle of a frame.
    logic                   fval_fall;    // first cycle after a frame.
    logic                   lval_rise;    // first cycle of a line.
    logic                   lval_fall;    // first cycle after a line.
    logic                   data_en;      // the data word carries pixels.
    logic [13:0]            pixel_count;  // pixels so far in the frame.
    logic [`CL_COORD_W-1:0] frame_x;      // pixel position in the line.
    logic [`CL_COORD_W-1:0] frame_y;      // line number in the frame.
  } cl_timing_t;

  // one registered word of pixels.
  typedef struct packed {
    cl_pixel_t [`CL_TAPS-1:0] pixels;     // tap 0 sits in the low bits.
    logic [2:0]               count;      // valid taps, 1 or 4.
    logic                     sof;        // first beat of the frame.
    logic                     sol;        // first beat of a line.
    logic [`CL_COORD_W-1:0]   x;          // position of tap 0.
  } cl_pixel_beat_t;

endpackage

`default_nettype wire

// ==== source/cl_ctrl_pkg.sv ====
/* Types for the format setting, the frame measurement and the host status port. */

`default_nettype none

`include "cl_macros.svh"

package cl_ctrl_pkg;

  typedef enum logic {
    CL_FMT_BASE,  // one pixel per word.
    CL_FMT_FULL   // four pixels per word.
  } cl_format_e;

  typedef struct packed {
    logic [`CL_COORD_W-1:0] height;
    logic [`CL_COORD_W-1:0] width;
  } cl_frame_size_t;

  typedef enum logic [1:0] {
    ST_SIZE  = 2'd0,  // height above, width below.
    ST_COUNT = 2'd1,  // completed frames.
    ST_FLAGS = 2'd2,  // bit 1 in frame, bit 0 irregular.
    ST_LIVE  = 2'd3   // frame_y above, frame_x below.
  } cl_status_addr_e;

  typedef struct packed {
    logic            req;
    cl_status_addr_e addr;
  } cl_status_req_t;

  typedef struct packed {
    logic                    ack;
    logic [`CL_STATUS_W-1:0] rdata;
  } cl_status_rsp_t;

endpackage

`default_nettype wire

// ==== source/cl_timing_tracker.sv ====
/* Frame timing of the camera stream: edge pulses, data enable, pixel counter
   and x/y position. Its timing bundle feeds every other block of the receiver. */

`timescale 1ns/1ps
`default_nettype none

`include "cl_macros.svh"

module cl_timing_tracker
  (
    input  logic                     cl_clk,
    input  logic                     reset,
    input  logic                     fval,
    input  logic                     lval,
    input  logic                     dval,
    input  cl_ctrl_pkg::cl_format_e  format,
    output cl_video_pkg::cl_timing_t timing
  );

  import cl_video_pkg::*;
  import cl_ctrl_pkg::*;

  logic                   fval_q;       // fval one cycle earlier.
  logic                   lval_q;       // lval one cycle earlier.
  logic                   data_en;
  logic [2:0]             step;
  logic [13:0]            pixel_count;
  logic [`CL_COORD_W-1:0] frame_x;
  logic [`CL_COORD_W-1:0] frame_y;

  assign data_en = fval & lval & dval;  // all three valids mark a pixel word.
  assign step    = (format == CL_FMT_FULL) ? 3'(`CL_TAPS) : 3'd1;

  always_ff @(posedge cl_clk)
  begin
    if (reset)
    begin
      fval_q <= 1'b0;
      lval_q <= 1'b0;
    end
    else
    begin
      fval_q <= fval;
      lval_q <= lval;
    end
  end

  // pixel counter over the whole frame.
  always_ff @(posedge cl_clk)
  begin
    if (reset || !fval)
      pixel_count <= '0;
    else if (data_en)
    begin
      if (pixel_count > `CL_PIXEL_WRAP)
        pixel_count <= '0;  // wraps on the next word once past the limit.
      else
        pixel_count <= pixel_count + 14'(step);
    end
  end

  // x restarts at every line; y counts finished lines of the frame.
  always_ff @(posedge cl_clk)
  begin
    if (reset || !fval || !lval)
      frame_x <= '0;
    else if (data_en)
      frame_x <= frame_x + `CL_COORD_W'(step);
  end

  always_ff @(posedge cl_clk)
  begin
    if (reset || !fval)
      frame_y <= '0;
    else if (!lval && lval_q)
      frame_y <= frame_y + 1'b1;
  end

  always_comb
  begin
    timing.fval_rise   = fval & ~fval_q;
    timing.fval_fall   = ~fval & fval_q;
    timing.lval_rise   = lval & ~lval_q;
    timing.lval_fall   = ~lval & lval_q;
    timing.data_en     = data_en;
    timing.pixel_count = pixel_count;
    timing.frame_x     = frame_x;
    timing.frame_y     = frame_y;
  end

  // outside a line the position must sit at zero on the next cycle.
  a_x_idle_outside_line : assert property (
    @(posedge cl_clk) disable iff (reset)
    !lval |=> (frame_x == '0)
  );

endmodule

`default_nettype wire

// ==== source/cl_pixel_unpack.sv ====
/* Splits each enabled camera word into a registered beat of 16-bit pixels,
   one pixel in base format and four in full format, one cycle after the word. */

`timescale 1ns/1ps
`default_nettype none

`include "cl_macros.svh"

module cl_pixel_unpack
  (
    input  logic                         cl_clk,
    input  logic                         reset,
    input  logic [`CL_DATA_W-1:0]        data,
    input  cl_ctrl_pkg::cl_format_e      format,
    input  cl_video_pkg::cl_timing_t     timing,
    output logic                         pixel_valid,
    output cl_video_pkg::cl_pixel_beat_t pixel_beat
  );

  import cl_video_pkg::*;
  import cl_ctrl_pkg::*;

  cl_pixel_beat_t beat_next;

  // build the beat from the word and the position that it lands at.
  always_comb
  begin
    beat_next = '0;
    for (int tap = 0; tap < `CL_TAPS; tap++)
    begin
      if (format == CL_FMT_FULL || tap == 0)
        beat_next.pixels[tap] = data[tap*`CL_PIXEL_W +: `CL_PIXEL_W];
    end
    beat_next.count = (format == CL_FMT_FULL) ? 3'(`CL_TAPS) : 3'd1;
    beat_next.sol   = (timing.frame_x == '0);
    // only line 0 at x 0 opens a frame.
    beat_next.sof   = (timing.frame_x == '0) && (timing.frame_y == '0);
    beat_next.x     = timing.frame_x;
  end

  always_ff @(posedge cl_clk)
  begin
    if (reset)
      pixel_valid <= 1'b0;
    else
      pixel_valid <= timing.data_en;  // one beat per enabled word.
  end

  always_ff @(posedge cl_clk)
  begin
    if (timing.data_en)
      pixel_beat <= beat_next;
  end

  a_beat_count_legal : assert property (
    @(posedge cl_clk) disable iff (reset)
    pixel_valid |-> (pixel_beat.count inside {3'd1, 3'(`CL_TAPS)})
  );

endmodule

`default_nettype wire

// ==== source/cl_frame_measure.sv ====
/* Measures each frame from the timing bundle: last line width, line count,
   frame count and whether any line differed in width from the first one. */

`timescale 1ns/1ps
`default_nettype none

`include "cl_macros.svh"

module cl_frame_measure
  (
    input  logic                         cl_clk,
    input  logic                         reset,
    input  cl_video_pkg::cl_timing_t     timing,
    output cl_ctrl_pkg::cl_frame_size_t  frame_size,
    output logic [`CL_COORD_W-1:0]       frame_count,
    output logic                         irregular,
    output logic                         frame_done
  );

  import cl_video_pkg::*;
  import cl_ctrl_pkg::*;

  logic [`CL_COORD_W-1:0] line_width;   // width of the latest finished line.
  logic [`CL_COORD_W-1:0] first_width;  // width of line 0 of this frame.
  logic                   first_seen;
  logic                   mismatch;     // a line so far differed from line 0.
  logic                   line_differs;

  assign line_differs = timing.lval_fall && first_seen && (timing.frame_x != first_width);

  always_ff @(posedge cl_clk)
  begin
    if (reset || timing.fval_rise)
    begin
      line_width  <= '0;
      first_width <= '0;
      first_seen  <= 1'b0;
      mismatch    <= 1'b0;
    end
    else if (timing.lval_fall)
    begin
      line_width <= timing.frame_x;  // x still holds the line's length here.
      if (!first_seen)
      begin
        first_width <= timing.frame_x;
        first_seen  <= 1'b1;
      end
      mismatch <= mismatch | line_differs;
    end
  end

  // results move out when the frame ends, and are seen with frame_done.
  always_ff @(posedge cl_clk)
  begin
    if (reset)
    begin
      frame_size  <= '0;
      frame_count <= '0;
      irregular   <= 1'b0;
      frame_done  <= 1'b0;
    end
    else
    begin
      frame_done <= timing.fval_fall;
      if (timing.fval_fall)
      begin
        frame_size.width  <= timing.lval_fall ? timing.frame_x : line_width;
        frame_size.height <= timing.frame_y + `CL_COORD_W'(timing.lval_fall);
        frame_count       <= frame_count + 1'b1;
        irregular         <= mismatch | line_differs;
      end
    end
  end

  a_done_single_pulse : assert property (
    @(posedge cl_clk) disable iff (reset)
    frame_done |=> !frame_done
  );

endmodule

`default_nettype wire

// ==== source/cl_status_port.sv ====
/* Host readout of the measurement and live position over a four-phase
   req/ack handshake. ack rises two cycles after req and drops after req does. */

`timescale 1ns/1ps
`default_nettype none

`include "cl_macros.svh"

module cl_status_port
  (
    input  logic                        cl_clk,
    input  logic                        reset,
    input  cl_ctrl_pkg::cl_status_req_t status_req,
    output cl_ctrl_pkg::cl_status_rsp_t status_rsp,
    input  cl_ctrl_pkg::cl_frame_size_t frame_size,
    input  logic [`CL_COORD_W-1:0]      frame_count,
    input  logic                        irregular,
    input  cl_video_pkg::cl_timing_t    timing
  );

  import cl_video_pkg::*;
  import cl_ctrl_pkg::*;

  typedef enum logic [1:0] {IDLE, SELECT, ACK} state_e;

  state_e                  state;
  cl_status_addr_e         addr_q;    // address held for the whole transfer.
  logic [`CL_STATUS_W-1:0] rdata_q;
  logic                    in_frame;  // between fval rise and fval fall.

  always_ff @(posedge cl_clk)
  begin
    if (reset || timing.fval_fall)
      in_frame <= 1'b0;
    else if (timing.fval_rise)
      in_frame <= 1'b1;
  end

  always_ff @(posedge cl_clk)
  begin
    if (reset)
      state <= IDLE;
    else
    begin
      case (state)
        IDLE:    if (status_req.req) state <= SELECT;
        SELECT:  state <= ACK;
        ACK:     if (!status_req.req) state <= IDLE;  // ack drops one cycle later.
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge cl_clk)
  begin
    if (state == IDLE && status_req.req)
      addr_q <= status_req.addr;
    if (state == SELECT)
    begin
      case (addr_q)
        ST_SIZE:  rdata_q <= {frame_size.height, frame_size.width};
        ST_COUNT: rdata_q <= {{(`CL_STATUS_W-`CL_COORD_W){1'b0}}, frame_count};
        ST_FLAGS: rdata_q <= {{(`CL_STATUS_W-2){1'b0}}, in_frame, irregular};
        default:  rdata_q <= {timing.frame_y, timing.frame_x};
      endcase
    end
  end

  assign status_rsp.ack   = (state == ACK);
  assign status_rsp.rdata = rdata_q;

  // the host keeps req up until it has seen ack.
  a_req_held_until_ack : assert property (
    @(posedge cl_clk) disable iff (reset)
    (status_req.req && !status_rsp.ack) |=> (status_req.req || status_rsp.ack)
  );

endmodule

`default_nettype wire

// ==== source/cl_rx_top.sv ====
/* Camera Link receive front end: timing tracker, pixel unpacker, frame
   measurement and host status port, all on cl_clk. */

`timescale 1ns/1ps
`default_nettype none

`include "cl_macros.svh"

module cl_rx_top
  (
    input  logic                         cl_clk,
    input  logic                         reset,
    input  logic                         fval,
    input  logic                         lval,
    input  logic                         dval,
    input  logic [`CL_DATA_W-1:0]        data,
    input  cl_ctrl_pkg::cl_format_e      format,
    output logic                         pixel_valid,
    output cl_video_pkg::cl_pixel_beat_t pixel_beat,
    input  cl_ctrl_pkg::cl_status_req_t  status_req,
    output cl_ctrl_pkg::cl_status_rsp_t  status_rsp,
    output logic                         frame_done
  );

  import cl_video_pkg::*;
  import cl_ctrl_pkg::*;

  cl_timing_t             timing;
  cl_frame_size_t         frame_size;
  logic [`CL_COORD_W-1:0] frame_count;
  logic                   irregular;

  cl_timing_tracker u_timing (
    .cl_clk (cl_clk), .reset (reset),
    .fval   (fval), .lval (lval), .dval (dval),
    .format (format), .timing (timing)
  );

  cl_pixel_unpack u_unpack (
    .cl_clk      (cl_clk), .reset (reset),
    .data        (data), .format (format), .timing (timing),
    .pixel_valid (pixel_valid), .pixel_beat (pixel_beat)
  );

  cl_frame_measure u_measure (
    .cl_clk      (cl_clk), .reset (reset), .timing (timing),
    .frame_size  (frame_size), .frame_count (frame_count),
    .irregular   (irregular), .frame_done (frame_done)
  );

  cl_status_port u_status (
    .cl_clk      (cl_clk), .reset (reset),
    .status_req  (status_req), .status_rsp (status_rsp),
    .frame_size  (frame_size), .frame_count (frame_count),
    .irregular   (irregular), .timing (timing)
  );

endmodule

`default_nettype wire

// ==== dv/cl_rx_tb.sv ====
/* Testbench of the Camera Link receive front end. A camera model sends frames,
   a host model reads the status port, and concurrent assertions check the DUT. */

`timescale 1ns/1ps
`default_nettype none

`include "cl_macros.svh"

module cl_rx_tb;

  import cl_video_pkg::*;
  import cl_ctrl_pkg::*;

  localparam int STALL_MAX = 2;  // random dval gaps inside a line are 0 to 2 cycles.
  localparam int READ_MAX  = 8;  // cycles for one host read with margin.

  function automatic int frame_cycles(input int words, input int lines, input int line_gap);
    return 2 + lines * (words * (STALL_MAX + 1) + line_gap) + 3;
  endfunction

  localparam int RUN_LIMIT = frame_cycles(12, 5, 2) + frame_cycles(8, 3, 2)
                           + frame_cycles(6, 4, 1) + frame_cycles(10, 4, 2)
                           + frame_cycles(10, 3, 2) + frame_cycles(10, 4, 3)
                           + 12 * READ_MAX + 2 * 5 + 200;

  logic                   cl_clk;
  logic                   reset;
  logic                   fval;
  logic                   lval;
  logic                   dval;
  logic [`CL_DATA_W-1:0]  data;
  cl_format_e             format;
  logic                   pixel_valid;
  cl_pixel_beat_t         pixel_beat;
  cl_status_req_t         status_req;
  cl_status_rsp_t         status_rsp;
  logic                   frame_done;

  logic [31:0]            rng_state;
  int                     line_words[$];  // words in each line of the next frame.
  int                     lines_done;
  int                     frames_sent;
  logic                   word_sent;      // an enabled word is on the bus this cycle.
  cl_pixel_beat_t         exp_beat;
  logic                   beat_due;
  cl_pixel_beat_t         beat_exp;
  int                     cycle_count;
  string                  test_name;
  int                     tests_run;
  int                     tests_failed;
  int                     errors;
  int                     errors_at_start;

  cl_rx_top UUT (
    .cl_clk      (cl_clk),
    .reset       (reset),
    .fval        (fval),
    .lval        (lval),
    .dval        (dval),
    .data        (data),
    .format      (format),
    .pixel_valid (pixel_valid),
    .pixel_beat  (pixel_beat),
    .status_req  (status_req),
    .status_rsp  (status_rsp),
    .frame_done  (frame_done)
  );

  always #10 cl_clk = ~cl_clk;

  always @(posedge cl_clk)
  begin
    beat_due    <= word_sent;  // the beat of this word is due on the next edge.
    beat_exp    <= exp_beat;
    cycle_count <= cycle_count + 1;
    if (cycle_count > RUN_LIMIT)
    begin
      $display("the run timed out after %0d cycles in test %s", cycle_count, test_name);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  a_beat_timing : assert property (@(posedge cl_clk) disable iff (reset)
    pixel_valid == beat_due)
  else
  begin
    errors++;
    $display("in test %s, pixel_valid did not follow an enabled word by one cycle", test_name);
  end

  a_beat_value : assert property (@(posedge cl_clk) disable iff (reset)
    beat_due |-> (pixel_beat == beat_exp))
  else
  begin
    errors++;
    $display("ERROR %s pixel beat: expected %h actual %h", test_name,
             $sampled(beat_exp), $sampled(pixel_beat));
  end

  a_done_after_fall : assert property (@(posedge cl_clk) disable iff (reset)
    $fell(fval) |=> frame_done)
  else
  begin
    errors++;
    $display("in test %s, frame_done did not pulse one cycle after fval fell", test_name);
  end

  a_done_only_after_fall : assert property (@(posedge cl_clk) disable iff (reset)
    frame_done |-> ($past(fval, 2) && !$past(fval)))
  else
  begin
    errors++;
    $display("in test %s, frame_done pulsed without a fval fall one cycle earlier", test_name);
  end

  a_ack_delay : assert property (@(posedge cl_clk) disable iff (reset)
    $rose(status_req.req) |-> !status_rsp.ack ##1 !status_rsp.ack ##1 status_rsp.ack)
  else
  begin
    errors++;
    $display("in test %s, ack did not rise two cycles after req", test_name);
  end

  a_ack_hold : assert property (@(posedge cl_clk) disable iff (reset)
    (status_rsp.ack && status_req.req) |=> status_rsp.ack)
  else
  begin
    errors++;
    $display("in test %s, ack fell while req was still high", test_name);
  end

  a_ack_release : assert property (@(posedge cl_clk) disable iff (reset)
    (status_rsp.ack && !status_req.req) |=> !status_rsp.ack)
  else
  begin
    errors++;
    $display("in test %s, ack did not fall one cycle after req fell", test_name);
  end

  a_reset_quiet : assert property (@(posedge cl_clk)
    ((reset && $past(reset)) || $fell(reset)) |-> !(pixel_valid || frame_done || status_rsp.ack))
  else
  begin
    errors++;
    $display("in test %s, an output was high during or just after reset", test_name);
  end

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic fill_lines(input int words, input int lines);
    line_words.delete();
    for (int i = 0; i < lines; i++)
      line_words.push_back(words);
    lines_done = 0;  // cleared here so a forked host sees only this frame.
  endtask

  // one frame on falling edges; each enabled word also sets up its expected beat.
  task automatic send_frame(input cl_format_e fmt, input int line_gap, input bit stalls);
    int stall;
    int x;
    format = fmt;
    fval   = 1'b1;
    repeat (2) @(negedge cl_clk);
    for (int line = 0; line < line_words.size(); line++)
    begin
      x    = 0;
      lval = 1'b1;
      for (int w = 0; w < line_words[line]; w++)
      begin
        stall     = stalls ? int'(next_random() % (STALL_MAX + 1)) : 0;
        dval      = 1'b0;
        word_sent = 1'b0;
        repeat (stall) @(negedge cl_clk);
        data     = {next_random(), next_random()};
        exp_beat = '0;
        for (int t = 0; t < `CL_TAPS; t++)
          if (t == 0 || fmt == CL_FMT_FULL)
            exp_beat.pixels[t] = data[t*`CL_PIXEL_W +: `CL_PIXEL_W];
        exp_beat.count = (fmt == CL_FMT_FULL) ? 3'd4 : 3'd1;
        exp_beat.sol   = (x == 0);
        exp_beat.sof   = (x == 0) && (line == 0);
        exp_beat.x     = 16'(x);
        dval      = 1'b1;
        word_sent = 1'b1;
        @(negedge cl_clk);
        x += (fmt == CL_FMT_FULL) ? 4 : 1;
      end
      lval      = 1'b0;
      dval      = 1'b0;
      word_sent = 1'b0;
      lines_done++;
      repeat (line_gap) @(negedge cl_clk);
    end
    fval = 1'b0;
    frames_sent++;
    repeat (3) @(negedge cl_clk);
  endtask

  task automatic read_status(input cl_status_addr_e addr, output logic [31:0] rdata);
    status_req = '{req: 1'b1, addr: addr};
    @(negedge cl_clk);
    while (!status_rsp.ack)
      @(negedge cl_clk);
    rdata          = status_rsp.rdata;
    @(negedge cl_clk);  // the host holds req one more cycle with ack up.
    status_req.req = 1'b0;
    @(negedge cl_clk);
    while (status_rsp.ack)
      @(negedge cl_clk);  // a new req waits for ack to fall.
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      errors++;
      $display("ERROR %s %s: expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_true(input bit ok, input string what);
    assert (ok)
    else
    begin
      errors++;
      $display("in test %s, %s", test_name, what);
    end
  endtask

  task automatic read_during_frame();
    logic [31:0] rdata;
    wait (lines_done >= 1);
    @(negedge cl_clk);
    read_status(ST_LIVE, rdata);
    check_true(rdata[31:16] != 16'd0, "ST_LIVE showed frame_y zero after the first line");
    read_status(ST_FLAGS, rdata);
    check_value("ST_FLAGS in frame", 32'd1, {31'd0, rdata[1]});
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != errors_at_start)
      tests_failed++;
    $display("test %0d %s finished with %0d errors", tests_run, test_name,
             errors - errors_at_start);
  endtask

  initial
  begin
    logic [31:0] rdata;
    cl_clk      = 1'b0;
    reset       = 1'b1;
    fval        = 1'b0;
    lval        = 1'b0;
    dval        = 1'b0;
    data        = '0;
    format      = CL_FMT_BASE;
    status_req  = '0;
    word_sent   = 1'b0;
    exp_beat    = '0;
    beat_due    = 1'b0;
    rng_state   = 32'h3e68;
    cycle_count = 0;
    frames_sent = 0;
    lines_done  = 0;
    errors      = 0;
    test_name   = "startup";
    repeat (5) @(negedge cl_clk);
    reset = 1'b0;
    @(negedge cl_clk);

    begin_test("base_frame");
    fill_lines(12, 5);
    send_frame(CL_FMT_BASE, 2, 1'b1);
    read_status(ST_SIZE, rdata);
    check_value("ST_SIZE", {16'd5, 16'd12}, rdata);
    end_test();

    begin_test("full_frame");
    fill_lines(8, 3);
    send_frame(CL_FMT_FULL, 2, 1'b0);
    read_status(ST_SIZE, rdata);
    check_value("ST_SIZE", {16'd3, 16'd32}, rdata);
    read_status(ST_COUNT, rdata);
    check_value("ST_COUNT", 32'(frames_sent), rdata);
    end_test();

    begin_test("pixel_path");
    fill_lines(6, 4);
    send_frame(CL_FMT_FULL, 1, 1'b1);
    read_status(ST_SIZE, rdata);
    check_value("ST_SIZE", {16'd4, 16'd24}, rdata);
    end_test();

    begin_test("irregular_line");
    fill_lines(10, 4);
    line_words[2] = 7;  // line 2 is shorter than line 0.
    send_frame(CL_FMT_BASE, 2, 1'b0);
    read_status(ST_FLAGS, rdata);
    check_value("ST_FLAGS irregular", 32'd1, {31'd0, rdata[0]});
    fill_lines(10, 3);
    send_frame(CL_FMT_BASE, 2, 1'b0);
    read_status(ST_FLAGS, rdata);
    check_value("ST_FLAGS irregular", 32'd0, {31'd0, rdata[0]});
    read_status(ST_COUNT, rdata);
    check_value("ST_COUNT", 32'(frames_sent), rdata);
    end_test();

    begin_test("host_handshake");
    fill_lines(10, 4);
    fork
      send_frame(CL_FMT_BASE, 3, 1'b0);
      read_during_frame();
    join
    read_status(ST_FLAGS, rdata);
    check_value("ST_FLAGS between frames", 32'd0, {31'd0, rdata[1]});
    end_test();

    begin_test("reset");
    status_req = '{req: 1'b1, addr: ST_COUNT};
    @(negedge cl_clk);
    while (!status_rsp.ack)
      @(negedge cl_clk);
    fval  = 1'b1;  // reset lands with ack high and a word on the bus.
    lval  = 1'b1;
    dval  = 1'b1;
    reset = 1'b1;
    repeat (4) @(negedge cl_clk);
    status_req.req = 1'b0;
    fval           = 1'b0;
    lval           = 1'b0;
    dval           = 1'b0;
    @(negedge cl_clk);
    reset = 1'b0;
    @(negedge cl_clk);
    read_status(ST_COUNT, rdata);
    check_value("ST_COUNT", 32'd0, rdata);
    repeat (2) @(negedge cl_clk);
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+source
source/cl_video_pkg.sv
source/cl_ctrl_pkg.sv
source/cl_timing_tracker.sv
source/cl_pixel_unpack.sv
source/cl_frame_measure.sv
source/cl_status_port.sv
source/cl_rx_top.sv
dv/cl_rx_tb.sv

// ==== Bender.yml ====
package:
  name: cl_rx

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cl_video_pkg.sv
      - source/cl_ctrl_pkg.sv
      - source/cl_timing_tracker.sv
      - source/cl_pixel_unpack.sv
      - source/cl_frame_measure.sv
      - source/cl_status_port.sv
      - source/cl_rx_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/cl_rx_tb.sv
